// File: design/pool_pkg.sv
package pool_pkg;

	// input feature map from the conv layer
	localparam int img_width  = 30;
	localparam int img_height = 30;

	// pooled map, 2x2 window with stride 2
	localparam int out_width  = img_width / 2;
	localparam int out_height = img_height / 2;

	// conv output precision, shared by input and result
	localparam int pixel_bits = 22;

	// coordinate widths
	localparam int col_bits  = 5;
	localparam int row_bits  = 5;
	localparam int pair_bits = 4;

	typedef logic signed [pixel_bits-1:0] pixel_t;

	// input column 0..29
	typedef logic [col_bits-1:0] col_t;

	// input row 0..29
	typedef logic [row_bits-1:0] row_t;

	// pooled column 0..14
	typedef logic [pair_bits-1:0] pair_t;

	// frame control states
	typedef enum logic [1:0] {
		idle,
		processing,
		done
	} ctrl_state_t;

endpackage

// File: design/pool_ctrl.sv
`timescale 1ns/1ns

module pool_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic start_signal,
	input  logic pixel_valid,
	input  logic last_pixel,
	output logic accept,
	output logic frame_start,
	output logic done_signal
);

	pool_pkg::ctrl_state_t state;
	pool_pkg::ctrl_state_t next_state;

	// pixels only count while a frame is open
	assign accept = pixel_valid && (state == pool_pkg::processing);

	// start only honoured from idle
	assign frame_start = start_signal && (state == pool_pkg::idle);

	// one cycle in done per frame
	assign done_signal = (state == pool_pkg::done);

	always_comb begin
		next_state = state;
		case (state)
			pool_pkg::idle: begin
				if (frame_start) begin
					next_state = pool_pkg::processing;
				end
			end
			pool_pkg::processing: begin
				// leave on the last pixel of the map
				if (accept && last_pixel) begin
					next_state = pool_pkg::done;
				end
			end
			pool_pkg::done: begin
				next_state = pool_pkg::idle;
			end
			default: begin
				next_state = pool_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= pool_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

endmodule

// File: design/pool_position.sv
`timescale 1ns/1ns

module pool_position (
	input  logic            clk,
	input  logic            rst,
	input  logic            frame_start,
	input  logic            accept,
	output logic            col_odd,
	output logic            row_odd,
	output pool_pkg::pair_t pair,
	output logic            last_pixel
);

	pool_pkg::col_t col;
	pool_pkg::row_t row;

	logic col_last;
	logic row_wrap;

	// end of an input line
	assign col_last = (col == pool_pkg::col_t'(pool_pkg::img_width - 1));

	// bottom line of the map
	assign row_wrap = (row == pool_pkg::row_t'(pool_pkg::img_height - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
		end else if (frame_start) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (col_last) begin
				col <= '0;
				if (row_wrap) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// parity picks the window corner
	assign col_odd = col[0];
	assign row_odd = row[0];

	// column halved gives the pooled column
	assign pair = col[pool_pkg::col_bits-1:1];

	assign last_pixel = col_last && row_wrap;

endmodule

// File: design/pool_row_buffer.sv
`timescale 1ns/1ns

module pool_row_buffer (
	input  logic             clk,
	input  logic             rst,
	input  logic             accept,
	input  logic             col_odd,
	input  logic             row_odd,
	input  pool_pkg::pair_t  pair,
	input  pool_pkg::pixel_t pair_max,
	output pool_pkg::pixel_t upper_max
);

	// one horizontal pair max per pooled column
	pool_pkg::pixel_t pair_mem [pool_pkg::out_width];

	logic wr_en;

	// second pixel of a pair on the upper row of the window
	assign wr_en = accept && col_odd && !row_odd;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < pool_pkg::out_width; i++) begin
				pair_mem[i] <= '0;
			end
		end else if (wr_en) begin
			pair_mem[pair] <= pair_max;
		end
	end

	// read during the lower row, same index as the write
	assign upper_max = pair_mem[pair];

endmodule

// File: design/pool_window_max.sv
`timescale 1ns/1ns

module pool_window_max (
	input  logic             clk,
	input  logic             rst,
	input  logic             accept,
	input  logic             col_odd,
	input  logic             row_odd,
	input  pool_pkg::pixel_t pixel_in,
	input  pool_pkg::pixel_t upper_max,
	output pool_pkg::pixel_t pair_max,
	output pool_pkg::pixel_t result_out,
	output logic             result_valid
);

	// left pixel of the current pair
	pool_pkg::pixel_t prev_pixel;

	pool_pkg::pixel_t window_max;
	logic             block_close;

	always_ff @(posedge clk) begin
		if (accept) begin
			prev_pixel <= pixel_in;
		end
	end

	// signed compare, ties keep the held pixel
	always_comb begin
		if (pixel_in > prev_pixel) begin
			pair_max = pixel_in;
		end else begin
			pair_max = prev_pixel;
		end
	end

	// upper pair against lower pair
	always_comb begin
		if (pair_max > upper_max) begin
			window_max = pair_max;
		end else begin
			window_max = upper_max;
		end
	end

	// bottom right pixel of a 2x2 block
	assign block_close = accept && col_odd && row_odd;

	always_ff @(posedge clk) begin
		if (rst) begin
			result_out   <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= block_close;
			if (block_close) begin
				result_out <= window_max;
			end
		end
	end

endmodule

// File: design/max_pool_top.sv
`timescale 1ns/1ns

module max_pool_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             start_signal,
	input  logic             pixel_valid,
	input  pool_pkg::pixel_t pixel_in,
	output pool_pkg::pixel_t result_out,
	output logic             result_valid,
	output logic             done_signal
);

	logic             accept;
	logic             frame_start;
	logic             col_odd;
	logic             row_odd;
	logic             last_pixel;
	pool_pkg::pair_t  pair;
	pool_pkg::pixel_t pair_max;
	pool_pkg::pixel_t upper_max;

	pool_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.start_signal (start_signal),
		.pixel_valid  (pixel_valid),
		.last_pixel   (last_pixel),
		.accept       (accept),
		.frame_start  (frame_start),
		.done_signal  (done_signal)
	);

	pool_position u_position (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.accept      (accept),
		.col_odd     (col_odd),
		.row_odd     (row_odd),
		.pair        (pair),
		.last_pixel  (last_pixel)
	);

	pool_row_buffer u_row_buffer (
		.clk       (clk),
		.rst       (rst),
		.accept    (accept),
		.col_odd   (col_odd),
		.row_odd   (row_odd),
		.pair      (pair),
		.pair_max  (pair_max),
		.upper_max (upper_max)
	);

	pool_window_max u_window_max (
		.clk          (clk),
		.rst          (rst),
		.accept       (accept),
		.col_odd      (col_odd),
		.row_odd      (row_odd),
		.pixel_in     (pixel_in),
		.upper_max    (upper_max),
		.pair_max     (pair_max),
		.result_out   (result_out),
		.result_valid (result_valid)
	);

endmodule

// File: tb/tb_max_pool.sv
`timescale 1ns/1ns

module tb_max_pool;

	localparam int num_frames   = 4;
	localparam int frame_pixels = pool_pkg::img_width * pool_pkg::img_height;
	localparam int frame_blocks = pool_pkg::out_width * pool_pkg::out_height;
	localparam int cycle_limit  = num_frames * frame_pixels * 4 + 200;

	logic             clk;
	logic             rst;
	logic             start_signal;
	logic             pixel_valid;
	pool_pkg::pixel_t pixel_in;
	pool_pkg::pixel_t result_out;
	logic             result_valid;
	logic             done_signal;

	pool_pkg::pixel_t expected_q [$];
	pool_pkg::pixel_t pix [frame_pixels];

	string cur_test;
	int    errors;
	int    test_err_start;
	int    res_count;
	int    done_count;
	int    tests_passed;
	int    tests_failed;
	int    cycles;

	max_pool_top UUT (
		.clk          (clk),
		.rst          (rst),
		.start_signal (start_signal),
		.pixel_valid  (pixel_valid),
		.pixel_in     (pixel_in),
		.result_out   (result_out),
		.result_valid (result_valid),
		.done_signal  (done_signal)
	);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run went past %0d cycles without finishing",
				cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	// outputs checked mid-cycle on the falling edge
	always @(negedge clk) begin
		if (!rst && result_valid) begin
			assert (expected_q.size() > 0) else begin
				$display("%s: result_valid pulsed with no result expected", cur_test);
				errors++;
			end
			if (expected_q.size() > 0) begin
				assert (result_out == expected_q[0]) else begin
					$display("MISMATCH %s result %0d: expected %0d actual %0d",
						cur_test, res_count, expected_q[0], result_out);
					errors++;
				end
				void'(expected_q.pop_front());
			end
			res_count++;
		end
		if (!rst && done_signal) begin
			done_count++;
			assert (result_valid && res_count == frame_blocks) else begin
				$display("%s: done_signal not aligned with the last result (count %0d)",
					cur_test, res_count);
				errors++;
			end
		end
	end

	// extremes and small values for ties mixed with full-range noise
	function automatic pool_pkg::pixel_t gen_pixel(input bit extremes);
		int sel;
		if (extremes) begin
			sel = $urandom_range(0, 4);
		end else begin
			sel = $urandom_range(0, 9);
		end
		case (sel)
			0: return {1'b1, {(pool_pkg::pixel_bits-1){1'b0}}};
			1: return {1'b0, {(pool_pkg::pixel_bits-1){1'b1}}};
			2: return '1;
			3: return pool_pkg::pixel_t'(int'($urandom_range(0, 2)) - 1);
			4: return pool_pkg::pixel_t'(-int'($urandom_range(1, 8)));
			default: return pool_pkg::pixel_t'($urandom());
		endcase
	endfunction

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err_start = errors;
		res_count = 0;
		done_count = 0;
	endtask

	task automatic end_test();
		int n;
		n = errors - test_err_start;
		if (n == 0) begin
			tests_passed++;
			$display("test %s: ok, %0d results", cur_test, res_count);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", cur_test, n);
		end
	endtask

	// idle cycles with junk pixels that must be ignored
	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			start_signal = 1'b0;
			pixel_valid = $urandom_range(0, 1);
			pixel_in = gen_pixel(1'b0);
			step();
			assert (!result_valid && !done_signal) else begin
				$display("%s: result_valid or done_signal high while idle", cur_test);
				errors++;
			end
		end
	endtask

	// block maxima of the current frame in raster order
	task automatic build_model();
		pool_pkg::pixel_t m;
		int base;
		for (int br = 0; br < pool_pkg::out_height; br++) begin
			for (int bc = 0; bc < pool_pkg::out_width; bc++) begin
				base = 2 * br * pool_pkg::img_width + 2 * bc;
				m = pix[base];
				if (pix[base + 1] > m) begin
					m = pix[base + 1];
				end
				if (pix[base + pool_pkg::img_width] > m) begin
					m = pix[base + pool_pkg::img_width];
				end
				if (pix[base + pool_pkg::img_width + 1] > m) begin
					m = pix[base + pool_pkg::img_width + 1];
				end
				expected_q.push_back(m);
			end
		end
	endtask

	// runs from 10 ns after an edge to the cycle after done
	task automatic run_frame(input string name, input bit extremes, input bit start_noise);
		int gap;
		begin_test(name);
		for (int i = 0; i < frame_pixels; i++) begin
			pix[i] = gen_pixel(extremes);
		end
		build_model();
		start_signal = 1'b1;
		pixel_valid = 1'b0;
		step();
		for (int i = 0; i < frame_pixels; i++) begin
			gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 2) : 0;
			for (int g = 0; g < gap; g++) begin
				start_signal = start_noise && ($urandom_range(0, 3) == 0);
				pixel_valid = 1'b0;
				pixel_in = gen_pixel(1'b0);
				step();
			end
			start_signal = start_noise && ($urandom_range(0, 7) == 0);
			pixel_valid = 1'b1;
			pixel_in = pix[i];
			step();
		end
		// junk during the done cycle
		start_signal = 1'b0;
		pixel_valid = 1'b1;
		pixel_in = gen_pixel(1'b0);
		while (done_count == 0) begin
			step();
			pixel_valid = 1'b0;
		end
		assert (res_count == frame_blocks) else begin
			$display("MISMATCH %s result count: expected %0d actual %0d",
				name, frame_blocks, res_count);
			errors++;
		end
		// done must already be gone one cycle after it rose
		assert (!done_signal) else begin
			$display("%s: done_signal still high in the cycle after done", name);
			errors++;
		end
		assert (expected_q.size() == 0) else begin
			$display("%s: %0d expected results never arrived", name, expected_q.size());
			errors++;
			expected_q.delete();
		end
		end_test();
	endtask

	initial begin
		void'($urandom(32'h7bc1_6ed7));
		cur_test = "reset";
		rst = 1'b1;
		start_signal = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		repeat (16) @(posedge clk);
		#10;
		rst = 1'b0;

		begin_test("reset_idle");
		assert (result_valid == 1'b0 && done_signal == 1'b0 &&
			result_out == '0) else begin
			$display("reset_idle: outputs not cleared by reset");
			errors++;
		end
		idle_cycles(24);
		end_test();

		run_frame("frame_random", 1'b0, 1'b0);
		idle_cycles(8);
		run_frame("frame_extremes", 1'b1, 1'b0);
		idle_cycles(8);
		run_frame("frame_start_noise", 1'b0, 1'b1);
		// start lands in the cycle right after done
		run_frame("frame_back_to_back", 1'b1, 1'b0);

		begin_test("tail_idle");
		idle_cycles(20);
		end_test();

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: tb.f
design/pool_pkg.sv
design/pool_ctrl.sv
design/pool_position.sv
design/pool_row_buffer.sv
design/pool_window_max.sv
design/max_pool_top.sv
tb/tb_max_pool.sv

// File: Bender.yml
package:
  name: max_pool

dependencies: {}

sources:
  - files:
      - design/pool_pkg.sv
      - design/pool_ctrl.sv
      - design/pool_position.sv
      - design/pool_row_buffer.sv
      - design/pool_window_max.sv
      - design/max_pool_top.sv
  - target: test
    files:
      - tb/tb_max_pool.sv
